/* project.f */
+incdir+hw
+incdir+verif
hw/mips_pkg.sv
hw/mips_decoder.sv
hw/mips_reg_file.sv
hw/mips_alu.sv
hw/mips_load_store.sv
hw/mips_cpu_bus.sv
verif/mips_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := mips_tb
FILELIST  := project.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)

SRCS := $(wildcard hw/*.sv hw/*.svh verif/*.sv verif/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf $(OBJ_DIR)

/* verif/mips_ref_model.svh */
`ifndef MIPS_REF_MODEL_SVH
`define MIPS_REF_MODEL_SVH

typedef struct packed {
    word_t      addr;   // word aligned bus address.
    logic [3:0] be;
    word_t      data;   // little-endian bus view.
} store_t;

word_t  prog[$];        // program in core byte order.
word_t  model_regs [32];
word_t  model_data [64];
store_t exp_stores[$];
int     model_steps;

function automatic word_t swap_bytes(input word_t w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
endfunction

function automatic word_t enc_r(input reg_addr_t rs, input reg_addr_t rt, input reg_addr_t rd,
                                input logic [4:0] sh, input funct_t fn);
    return {`MIPS_OP_RTYPE, rs, rt, rd, sh, fn};
endfunction

function automatic word_t enc_i(input opcode_t op, input reg_addr_t rs, input reg_addr_t rt,
                                input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

function automatic void emit(input word_t w);
    prog.push_back(w);
endfunction

function automatic void build_program();
    word_t j_dest;
    emit(enc_i(`MIPS_OP_ADDIU, 0, 8, 16'h1000));        // data base.
    emit(enc_i(`MIPS_OP_ADDIU, 0, 9, 16'hFFFB));        // -5.
    emit(enc_i(`MIPS_OP_ADDIU, 0, 10, 16'h0003));
    emit(enc_r(9, 10, 11, 0, `MIPS_FN_ADDU));
    emit(enc_i(`MIPS_OP_SW, 8, 11, 16'd0));
    emit(enc_r(10, 9, 11, 0, `MIPS_FN_SUBU));
    emit(enc_i(`MIPS_OP_SW, 8, 11, 16'd4));
    emit(enc_r(9, 10, 11, 0, `MIPS_FN_AND));
    emit(enc_i(`MIPS_OP_SW, 8, 11, 16'd8));
    emit(enc_r(9, 10, 11, 0, `MIPS_FN_OR));
    emit(enc_i(`MIPS_OP_SW, 8, 11, 16'd12));
    emit(enc_r(9, 10, 11, 0, `MIPS_FN_XOR));
    emit(enc_i(`MIPS_OP_SW, 8, 11, 16'd16));
    emit(enc_r(9, 10, 11, 0, `MIPS_FN_SLT));           // negative < positive.
    emit(enc_i(`MIPS_OP_SW, 8, 11, 16'd20));
    emit(enc_r(10, 9, 11, 0, `MIPS_FN_SLT));
    emit(enc_i(`MIPS_OP_SW, 8, 11, 16'd24));
    emit(enc_r(0, 9, 11, 4, `MIPS_FN_SLL));
    emit(enc_i(`MIPS_OP_SW, 8, 11, 16'd28));
    emit(enc_r(0, 9, 11, 4, `MIPS_FN_SRL));
    emit(enc_i(`MIPS_OP_SW, 8, 11, 16'd32));
    emit(enc_r(0, 9, 11, 4, `MIPS_FN_SRA));
    emit(enc_i(`MIPS_OP_SW, 8, 11, 16'd36));
    emit(enc_i(`MIPS_OP_ORI, 9, 11, 16'h8001));
    emit(enc_i(`MIPS_OP_SW, 8, 11, 16'd40));
    emit(enc_i(`MIPS_OP_LUI, 0, 11, 16'h1234));
    emit(enc_i(`MIPS_OP_SW, 8, 11, 16'd44));
    emit(enc_i(`MIPS_OP_ADDIU, 0, 12, 16'h0080));
    emit(enc_i(`MIPS_OP_ADDIU, 0, 13, 16'h005A));
    emit(enc_i(`MIPS_OP_SB, 8, 12, 16'd48));            // one per byte offset.
    emit(enc_i(`MIPS_OP_SB, 8, 13, 16'd49));
    emit(enc_i(`MIPS_OP_SB, 8, 10, 16'd50));
    emit(enc_i(`MIPS_OP_SB, 8, 9, 16'd51));
    emit(enc_i(`MIPS_OP_LB, 8, 14, 16'd48));
    emit(enc_i(`MIPS_OP_SW, 8, 14, 16'd56));
    emit(enc_i(`MIPS_OP_LBU, 8, 15, 16'd48));
    emit(enc_i(`MIPS_OP_SW, 8, 15, 16'd60));
    emit(enc_i(`MIPS_OP_LW, 8, 16, 16'd48));            // four distinct bytes.
    emit(enc_i(`MIPS_OP_SW, 8, 16, 16'd64));
    emit(enc_i(`MIPS_OP_BEQ, 10, 10, 16'd2));          // taken.
    emit(enc_i(`MIPS_OP_ADDIU, 2, 2, 16'd1));
    emit(enc_i(`MIPS_OP_ADDIU, 2, 2, 16'd100));
    emit(enc_i(`MIPS_OP_BNE, 10, 10, 16'd2));          // not taken.
    emit(enc_i(`MIPS_OP_ADDIU, 2, 2, 16'd2));
    emit(enc_i(`MIPS_OP_ADDIU, 2, 2, 16'd4));
    emit(enc_i(`MIPS_OP_BNE, 9, 10, 16'd2));
    emit(enc_i(`MIPS_OP_ADDIU, 2, 2, 16'd8));
    emit(enc_i(`MIPS_OP_ADDIU, 2, 2, 16'd200));
    emit(enc_i(`MIPS_OP_BEQ, 9, 10, 16'd2));
    emit(enc_i(`MIPS_OP_ADDIU, 2, 2, 16'd16));
    emit(enc_i(`MIPS_OP_SW, 8, 2, 16'd68));
    j_dest = `MIPS_RESET_VECTOR + 32'(4 * (prog.size() + 3));
    emit({`MIPS_OP_J, j_dest[27:2]});
    emit(enc_i(`MIPS_OP_ADDIU, 2, 2, 16'd32));
    emit(enc_i(`MIPS_OP_ADDIU, 2, 2, 16'd400));
    emit(enc_i(`MIPS_OP_SW, 8, 2, 16'd72));
    emit(enc_r(0, 0, 0, 0, `MIPS_FN_JR));               // jr $zero halts.
    emit(enc_i(`MIPS_OP_ADDIU, 2, 2, 16'd64));
endfunction

// instruction-set model, returns the final $v0.
function automatic word_t run_model();
    word_t pc, npc, nnpc, ins, rsv, rtv, imm_s, addr, res, w;
    reg_addr_t rs, rt, rd;
    logic [1:0] k;
    logic       wr;
    pc  = `MIPS_RESET_VECTOR;
    npc = pc + 32'd4;
    model_steps = 0;
    while (pc != `MIPS_HALT_ADDR && model_steps < 2000) begin
        ins   = prog[(pc - `MIPS_RESET_VECTOR) >> 2];
        rs    = ins[25:21];
        rt    = ins[20:16];
        rd    = ins[15:11];
        rsv   = model_regs[rs];
        rtv   = model_regs[rt];
        imm_s = {{16{ins[15]}}, ins[15:0]};
        addr  = rsv + imm_s;
        k     = addr[1:0];
        w     = model_data[addr[7:2]];
        nnpc  = npc + 32'd4;
        wr    = 1'b1;
        res   = '0;
        case (ins[31:26])
            `MIPS_OP_RTYPE: begin
                case (ins[5:0])
                    `MIPS_FN_ADDU: res = rsv + rtv;
                    `MIPS_FN_SUBU: res = rsv - rtv;
                    `MIPS_FN_AND:  res = rsv & rtv;
                    `MIPS_FN_OR:   res = rsv | rtv;
                    `MIPS_FN_XOR:  res = rsv ^ rtv;
                    `MIPS_FN_SLT:  res = ($signed(rsv) < $signed(rtv)) ? 32'd1 : 32'd0;
                    `MIPS_FN_SLL:  res = rtv << ins[10:6];
                    `MIPS_FN_SRL:  res = rtv >> ins[10:6];
                    `MIPS_FN_SRA:  res = $signed(rtv) >>> ins[10:6];
                    `MIPS_FN_JR: begin
                        wr   = 1'b0;
                        nnpc = rsv;
                    end
                    default: wr = 1'b0;
                endcase
                rt = rd;
            end
            `MIPS_OP_ADDIU: res = addr;
            `MIPS_OP_ORI:   res = rsv | {16'h0000, ins[15:0]};
            `MIPS_OP_LUI:   res = {ins[15:0], 16'h0000};
            `MIPS_OP_LW:    res = swap_bytes(w);
            `MIPS_OP_LB:    res = {{24{w[8*k+7]}}, w[8*k +: 8]};
            `MIPS_OP_LBU:   res = {24'h000000, w[8*k +: 8]};
            `MIPS_OP_SW: begin
                wr = 1'b0;
                model_data[addr[7:2]] = swap_bytes(rtv);
                exp_stores.push_back('{{addr[31:2], 2'b00}, 4'hF, swap_bytes(rtv)});
            end
            `MIPS_OP_SB: begin
                wr = 1'b0;
                w[8*k +: 8] = rtv[7:0];                 // bus lane k is byte offset k.
                model_data[addr[7:2]] = w;
                exp_stores.push_back('{{addr[31:2], 2'b00}, 4'b0001 << k, {4{rtv[7:0]}}});
            end
            `MIPS_OP_BEQ: begin
                wr = 1'b0;
                if (rsv == rtv) nnpc = npc + {imm_s[29:0], 2'b00};
            end
            `MIPS_OP_BNE: begin
                wr = 1'b0;
                if (rsv != rtv) nnpc = npc + {imm_s[29:0], 2'b00};
            end
            `MIPS_OP_J: begin
                wr   = 1'b0;
                nnpc = {npc[31:28], ins[25:0], 2'b00};
            end
            default: wr = 1'b0;
        endcase
        if (wr && rt != 5'd0) model_regs[rt] = res;
        pc  = npc;
        npc = nnpc;
        model_steps++;
    end
    return model_regs[2];
endfunction

`endif

/* verif/mips_tb.sv */
`timescale 1ns/1ps
`include "mips_consts.svh"

module mips_tb
    import mips_pkg::*;
;
    localparam word_t DATA_BASE = 32'h0000_1000;

    logic       clk;
    logic       reset;
    logic       active;
    word_t      register_v0;
    word_t      address;
    logic       read;
    logic       write;
    logic       waitrequest;
    word_t      writedata;
    logic [3:0] byteenable;
    word_t      readdata;

    word_t prog_mem [256];
    word_t data_mem [64];
    word_t lfsr_state;
    word_t exp_v0;
    int    cycle_count;
    int    cycle_limit;
    logic  halted;

    `include "mips_ref_model.svh"

    mips_cpu_bus i_mips_cpu_bus (
        .clk         (clk),
        .reset       (reset),
        .active      (active),
        .register_v0 (register_v0),
        .address     (address),
        .read        (read),
        .write       (write),
        .waitrequest (waitrequest),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .readdata    (readdata)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // fibonacci lfsr, taps 32 22 2 1.
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic word_t bus_read(input word_t a);
        word_t off;
        off = a - `MIPS_RESET_VECTOR;
        if (off < 32'd1024) return prog_mem[off[9:2]];
        off = a - DATA_BASE;
        if (off < 32'd256) return data_mem[off[7:2]];
        return ~a ^ 32'h3c3c_a5a5;              // unmapped space.
    endfunction

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_word(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
            stop_with_error("value mismatch");
        end
    endtask

    task automatic check_store(input store_t got);
        store_t exp;
        if (exp_stores.size() == 0) begin
            stop_with_error($sformatf("bus write to %h with no store left to expect", got.addr));
        end else begin
            exp = exp_stores.pop_front();
            if (got !== exp) begin
                $display("FAIL %0t: store got %h/%b/%h expected %h/%b/%h", $time,
                         got.addr, got.be, got.data, exp.addr, exp.be, exp.data);
                stop_with_error("store mismatch");
            end
        end
    endtask

    // memory model and bus checks.
    always @(posedge clk) begin
        logic [1:0] r;
        word_t      w;
        store_t     st;
        r = {lfsr_bit(), lfsr_bit()};
        waitrequest <= (r == 2'b11);            // busy one cycle in four.
        if (!reset) begin
            cycle_count <= cycle_count + 1;
            if (cycle_count >= cycle_limit) begin
                stop_with_error($sformatf("timeout, core still running after %0d cycles",
                                          cycle_count));
            end
            if (halted && (active || read || write)) begin
                stop_with_error("bus activity or active seen after the halt");
            end
            if (active === 1'b0) halted <= 1'b1;
            if (read && !waitrequest) readdata <= bus_read(address);
            if (write && !waitrequest) begin
                st = '{address, byteenable, writedata};
                check_store(st);
                w = bus_read(address);
                for (int i = 0; i < 4; i++) begin
                    if (byteenable[i]) w[8*i +: 8] = writedata[8*i +: 8];
                end
                if (address - DATA_BASE < 32'd256) data_mem[address[7:2]] <= w;
            end
        end
    end

    initial begin
        reset       = 1'b1;
        waitrequest = 1'b1;
        readdata    = '0;
        halted      = 1'b0;
        cycle_count = 0;
        lfsr_state  = 32'h8e07_1bab;
        for (int i = 0; i < 32; i++) model_regs[i] = '0;
        for (int i = 0; i < 64; i++) begin
            model_data[i] = '0;
            data_mem[i]   = '0;
        end
        for (int i = 0; i < 256; i++) prog_mem[i] = ~(`MIPS_RESET_VECTOR + 32'(4 * i));
        build_program();
        foreach (prog[i]) prog_mem[i] = swap_bytes(prog[i]);   // bus is little-endian.
        exp_v0      = run_model();
        cycle_limit = 40 * model_steps + 100;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        do @(posedge clk); while (!halted);
        repeat (20) @(posedge clk);
        check_word("register_v0", register_v0, exp_v0);
        if (exp_stores.size() == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            $display("%0d expected stores never seen on the bus", exp_stores.size());
            $display("tests failed");
            $fatal(1, "simulation stopped on error");
        end
    end

endmodule

/* hw/mips_cpu_bus.sv */
`timescale 1ns/1ps
`include "mips_consts.svh"

module mips_cpu_bus
    import mips_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    output logic       active,
    output word_t      register_v0,
    output word_t      address,
    output logic       read,
    output logic       write,
    input  logic       waitrequest,
    output word_t      writedata,
    output logic [3:0] byteenable,
    input  word_t      readdata
);
    cpu_state_t     state;
    word_t          pc;
    word_t          ir;
    logic           ir_fresh;        // readdata holds the instruction this cycle.
    word_t          branch_target;
    logic           branch_pending;
    word_t          instr_word;
    decoded_instr_t dec;
    word_t          rs_val;
    word_t          rt_val;
    word_t          alu_b;
    logic [4:0]     alu_shamt;
    word_t          alu_result;
    logic           alu_equal;
    logic           reg_write_en;
    word_t          reg_write_data;
    word_t          load_value;
    logic [3:0]     ls_byteenable;
    logic           is_load;
    logic           is_store;
    logic           branch_taken;
    word_t          branch_dest;

    assign instr_word = (state == STATE_EXECUTE && ir_fresh) ? byte_swap(readdata) : ir;
    assign is_load    = dec.mem_kind inside {MEM_LW, MEM_LB, MEM_LBU};
    assign is_store   = dec.mem_kind inside {MEM_SW, MEM_SB};
    assign active     = !(state == STATE_FETCH && pc == `MIPS_HALT_ADDR);

    assign alu_b     = dec.alu_b_imm ? dec.imm : rt_val;
    assign alu_shamt = dec.shift_imm ? instr_word[10:6] : rs_val[4:0];

    // loads write back one cycle after the read is accepted.
    assign reg_write_en   = (state == STATE_EXECUTE && dec.reg_write && !is_load) ||
                            (state == STATE_MEMORY);
    assign reg_write_data = (state == STATE_MEMORY) ? load_value : alu_result;

    assign read       = (state == STATE_FETCH && active) || (state == STATE_EXECUTE && is_load);
    assign write      = (state == STATE_EXECUTE && is_store);
    assign address    = (state == STATE_FETCH) ? pc : {alu_result[31:2], 2'b00};
    assign byteenable = (state == STATE_FETCH) ? 4'b1111 : ls_byteenable;

    // pc already points at the delay slot here.
    always_comb begin
        case (dec.branch_kind)
            BR_EQ: begin
                branch_taken = alu_equal;
                branch_dest  = pc + {dec.imm[29:0], 2'b00};
            end
            BR_NE: begin
                branch_taken = !alu_equal;
                branch_dest  = pc + {dec.imm[29:0], 2'b00};
            end
            BR_J: begin
                branch_taken = 1'b1;
                branch_dest  = {pc[31:28], dec.jump_target, 2'b00};
            end
            BR_JR: begin
                branch_taken = 1'b1;
                branch_dest  = rs_val;
            end
            default: begin
                branch_taken = 1'b0;
                branch_dest  = pc;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state          <= STATE_FETCH;
            pc             <= `MIPS_RESET_VECTOR;
            ir_fresh       <= 1'b0;
            branch_pending <= 1'b0;
        end else if (active) begin    // halted core freezes.
            case (state)
                STATE_FETCH: begin
                    if (!waitrequest) begin
                        pc       <= pc + 32'd4;
                        ir_fresh <= 1'b1;
                        state    <= STATE_EXECUTE;
                    end
                end
                STATE_EXECUTE: begin
                    ir       <= instr_word;
                    ir_fresh <= 1'b0;
                    if (branch_pending) begin       // delay slot runs now.
                        pc             <= branch_target;
                        branch_pending <= 1'b0;
                    end else if (branch_taken) begin
                        branch_target  <= branch_dest;
                        branch_pending <= 1'b1;
                    end
                    if (is_load) begin
                        if (!waitrequest) begin
                            state <= STATE_MEMORY;
                        end
                    end else if (is_store) begin
                        if (!waitrequest) begin
                            state <= STATE_FETCH;
                        end
                    end else begin
                        state <= STATE_FETCH;
                    end
                end
                STATE_MEMORY: state <= STATE_FETCH;
                default:      state <= STATE_FETCH;
            endcase
        end
    end

    mips_decoder i_mips_decoder (
        .instr (instr_word),
        .dec   (dec)
    );

    mips_reg_file i_mips_reg_file (
        .clk         (clk),
        .reset       (reset),
        .rs_addr     (dec.rs),
        .rt_addr     (dec.rt),
        .write_addr  (dec.dest),
        .write_en    (reg_write_en),
        .write_data  (reg_write_data),
        .rs_val      (rs_val),
        .rt_val      (rt_val),
        .register_v0 (register_v0)
    );

    mips_alu i_mips_alu (
        .a      (rs_val),
        .b      (alu_b),
        .shamt  (alu_shamt),
        .op     (dec.alu_op),
        .result (alu_result),
        .equal  (alu_equal)
    );

    mips_load_store i_mips_load_store (
        .kind          (dec.mem_kind),
        .byte_sel      (alu_result[1:0]),
        .rt_val        (rt_val),
        .bus_readdata  (readdata),
        .bus_writedata (writedata),
        .byteenable    (ls_byteenable),
        .load_value    (load_value)
    );

    read_write_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(read && write));

    // a stalled command keeps its address and kind until accepted.
    command_held: assert property (@(posedge clk) disable iff (reset)
        (read || write) && waitrequest |=> $stable(address) && $stable(read) &&
        $stable(write));

endmodule

/* hw/mips_load_store.sv */
`timescale 1ns/1ps

module mips_load_store
    import mips_pkg::*;
(
    input  mem_kind_t  kind,
    input  logic [1:0] byte_sel,
    input  word_t      rt_val,
    input  word_t      bus_readdata,
    output word_t      bus_writedata,
    output logic [3:0] byteenable,
    output word_t      load_value
);
    word_t      core_rdata;
    word_t      core_wdata;
    logic [3:0] core_lanes;   // bit 3 is byte offset 0.
    logic [7:0] sel_byte;

    assign core_rdata    = byte_swap(bus_readdata);
    assign bus_writedata = byte_swap(core_wdata);
    assign byteenable    = {core_lanes[0], core_lanes[1], core_lanes[2], core_lanes[3]};

    always_comb begin
        case (byte_sel)
            2'd0:    sel_byte = core_rdata[31:24];
            2'd1:    sel_byte = core_rdata[23:16];
            2'd2:    sel_byte = core_rdata[15:8];
            default: sel_byte = core_rdata[7:0];
        endcase
    end

    always_comb begin
        case (kind)
            MEM_SB, MEM_LB, MEM_LBU: core_lanes = 4'b1000 >> byte_sel;
            default:                 core_lanes = 4'b1111;
        endcase
    end

    // lane selection does the placement, so the byte goes everywhere.
    assign core_wdata = (kind == MEM_SB) ? {4{rt_val[7:0]}} : rt_val;

    always_comb begin
        case (kind)
            MEM_LB:  load_value = {{24{sel_byte[7]}}, sel_byte};
            MEM_LBU: load_value = {24'h000000, sel_byte};
            default: load_value = core_rdata;
        endcase
    end

    always_comb begin
        if (kind == MEM_SW || kind == MEM_SB) begin
            store_lanes_set: assert (byteenable != 4'b0000)
                else $error("store with no byte lane enabled.");
        end
    end

endmodule

/* hw/mips_alu.sv */
`timescale 1ns/1ps

module mips_alu
    import mips_pkg::*;
(
    input  word_t      a,
    input  word_t      b,
    input  logic [4:0] shamt,
    input  alu_op_t    op,
    output word_t      result,
    output logic       equal
);
    logic less_signed;

    assign less_signed = $signed(a) < $signed(b);
    assign equal       = (a == b);  // used by beq and bne.

    always_comb begin
        case (op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            ALU_SLT: result = {31'b0, less_signed};
            ALU_SLL: result = b << shamt;     // shifts act on rt.
            ALU_SRL: result = b >> shamt;
            ALU_SRA: result = $signed(b) >>> shamt;
            ALU_LUI: result = b;              // imm arrives pre-shifted.
            default: result = a + b;
        endcase
    end

endmodule

/* hw/mips_reg_file.sv */
`timescale 1ns/1ps
`include "mips_consts.svh"

module mips_reg_file
    import mips_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  reg_addr_t rs_addr,
    input  reg_addr_t rt_addr,
    input  reg_addr_t write_addr,
    input  logic      write_en,
    input  word_t     write_data,
    output word_t     rs_val,
    output word_t     rt_val,
    output word_t     register_v0
);
    word_t regs [`MIPS_NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en && write_addr != 5'd0) begin  // $zero stays zero.
            regs[write_addr] <= write_data;
        end
    end

    assign rs_val      = regs[rs_addr];
    assign rt_val      = regs[rt_addr];
    assign register_v0 = regs[2];  // $v0.

endmodule

/* hw/mips_decoder.sv */
`timescale 1ns/1ps
`include "mips_consts.svh"

module mips_decoder
    import mips_pkg::*;
(
    input  word_t          instr,
    output decoded_instr_t dec
);
    opcode_t opcode;
    funct_t  funct;
    word_t   imm_sign;
    word_t   imm_zero;
    word_t   imm_upper;

    assign opcode    = instr[31:26];
    assign funct     = instr[5:0];
    assign imm_sign  = {{16{instr[15]}}, instr[15:0]};
    assign imm_zero  = {16'h0000, instr[15:0]};
    assign imm_upper = {instr[15:0], 16'h0000};

    always_comb begin
        dec             = '0;           // anything unknown is a nop.
        dec.rs          = instr[25:21];
        dec.rt          = instr[20:16];
        dec.dest        = instr[20:16];
        dec.imm         = imm_sign;
        dec.alu_op      = ALU_ADD;
        dec.mem_kind    = MEM_NONE;
        dec.branch_kind = BR_NONE;
        dec.jump_target = instr[25:0];

        case (opcode)
            `MIPS_OP_RTYPE: begin
                dec.dest      = instr[15:11];
                dec.reg_write = 1'b1;
                case (funct)
                    `MIPS_FN_ADDU: dec.alu_op = ALU_ADD;
                    `MIPS_FN_SUBU: dec.alu_op = ALU_SUB;
                    `MIPS_FN_AND:  dec.alu_op = ALU_AND;
                    `MIPS_FN_OR:   dec.alu_op = ALU_OR;
                    `MIPS_FN_XOR:  dec.alu_op = ALU_XOR;
                    `MIPS_FN_SLT:  dec.alu_op = ALU_SLT;
                    `MIPS_FN_SLL: begin
                        dec.alu_op    = ALU_SLL;
                        dec.shift_imm = 1'b1;
                    end
                    `MIPS_FN_SRL: begin
                        dec.alu_op    = ALU_SRL;
                        dec.shift_imm = 1'b1;
                    end
                    `MIPS_FN_SRA: begin
                        dec.alu_op    = ALU_SRA;
                        dec.shift_imm = 1'b1;
                    end
                    `MIPS_FN_JR: begin
                        dec.reg_write   = 1'b0;
                        dec.branch_kind = BR_JR;
                    end
                    default: dec.reg_write = 1'b0;
                endcase
            end
            `MIPS_OP_J:   dec.branch_kind = BR_J;
            `MIPS_OP_BEQ: begin
                dec.alu_op      = ALU_SUB;  // only the equal flag matters.
                dec.branch_kind = BR_EQ;
            end
            `MIPS_OP_BNE: begin
                dec.alu_op      = ALU_SUB;
                dec.branch_kind = BR_NE;
            end
            `MIPS_OP_ADDIU: begin
                dec.alu_b_imm = 1'b1;
                dec.reg_write = 1'b1;
            end
            `MIPS_OP_ORI: begin
                dec.imm       = imm_zero;
                dec.alu_op    = ALU_OR;
                dec.alu_b_imm = 1'b1;
                dec.reg_write = 1'b1;
            end
            `MIPS_OP_LUI: begin
                dec.imm       = imm_upper;
                dec.alu_op    = ALU_LUI;
                dec.alu_b_imm = 1'b1;
                dec.reg_write = 1'b1;
            end
            `MIPS_OP_LW, `MIPS_OP_LB, `MIPS_OP_LBU: begin
                dec.alu_b_imm = 1'b1;
                dec.reg_write = 1'b1;       // written in the memory state.
                dec.mem_kind  = (opcode == `MIPS_OP_LW) ? MEM_LW :
                                (opcode == `MIPS_OP_LB) ? MEM_LB : MEM_LBU;
            end
            `MIPS_OP_SW: begin
                dec.alu_b_imm = 1'b1;
                dec.mem_kind  = MEM_SW;
            end
            `MIPS_OP_SB: begin
                dec.alu_b_imm = 1'b1;
                dec.mem_kind  = MEM_SB;
            end
            default: dec.reg_write = 1'b0;
        endcase
    end

endmodule

/* hw/mips_pkg.sv */
package mips_pkg;

    typedef logic [31:0] word_t;      // data or address word.
    typedef logic [4:0]  reg_addr_t;  // register index.
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;

    typedef enum logic [1:0] {
        STATE_FETCH,
        STATE_EXECUTE,
        STATE_MEMORY
    } cpu_state_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_t;

    typedef enum logic [2:0] {
        MEM_NONE,
        MEM_LW,
        MEM_LB,
        MEM_LBU,
        MEM_SW,
        MEM_SB
    } mem_kind_t;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_J,
        BR_JR
    } branch_kind_t;

    typedef struct packed {
        reg_addr_t    rs;
        reg_addr_t    rt;
        reg_addr_t    dest;         // rd for R-type, rt otherwise.
        word_t        imm;          // already extended or shifted.
        alu_op_t      alu_op;
        logic         alu_b_imm;    // operand b is imm, not rt.
        logic         shift_imm;    // shift amount from shamt field.
        logic         reg_write;
        mem_kind_t    mem_kind;
        branch_kind_t branch_kind;
        logic [25:0]  jump_target;
    } decoded_instr_t;

    // bus is little-endian, core is big-endian.
    function automatic word_t byte_swap(input word_t w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

endpackage

/* hw/mips_consts.svh */
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

`define MIPS_RESET_VECTOR 32'hBFC0_0000
`define MIPS_HALT_ADDR    32'h0000_0000
`define MIPS_NUM_REGS     32

// primary opcode field, instr[31:26].
`define MIPS_OP_RTYPE 6'h00
`define MIPS_OP_J     6'h02
`define MIPS_OP_BEQ   6'h04
`define MIPS_OP_BNE   6'h05
`define MIPS_OP_ADDIU 6'h09
`define MIPS_OP_ORI   6'h0D
`define MIPS_OP_LUI   6'h0F
`define MIPS_OP_LB    6'h20
`define MIPS_OP_LW    6'h23
`define MIPS_OP_LBU   6'h24
`define MIPS_OP_SB    6'h28
`define MIPS_OP_SW    6'h2B

// funct field for R-type, instr[5:0].
`define MIPS_FN_SLL  6'h00
`define MIPS_FN_SRL  6'h02
`define MIPS_FN_SRA  6'h03
`define MIPS_FN_JR   6'h08
`define MIPS_FN_ADDU 6'h21
`define MIPS_FN_SUBU 6'h23
`define MIPS_FN_AND  6'h24
`define MIPS_FN_OR   6'h25
`define MIPS_FN_XOR  6'h26
`define MIPS_FN_SLT  6'h2A

`endif
